/* rtl/ppu_background.sv */
//--------------------------------------------------------------------------
// Background layer top level: fetch sequencer, counters, addressing, shifter
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module ppu_background #(
	parameter int W_COORD = 9,
	parameter int W_ADDR  = 16
) (
	input  logic                         clk,
	input  logic                         rst_n,

	// Beam position
	input  logic [W_COORD-1:0]           beam_x,
	input  logic [W_COORD-1:0]           beam_y,

	input  logic                         en,
	input  logic                         flush,

	// Layer configuration
	input  logic [W_COORD-1:0]           cfg_scroll_x,
	input  logic [W_COORD-1:0]           cfg_scroll_y,
	input  logic [$clog2(W_COORD)-1:0]   cfg_log_w,
	input  logic [$clog2(W_COORD)-1:0]   cfg_log_h,
	input  logic [W_ADDR-1:0]            cfg_tilemap_base,
	input  logic [W_ADDR-1:0]            cfg_tileset_base,
	input  logic                         cfg_tile_size,
	input  ppu_cfg_pkg::pixel_mode_e     cfg_pixel_mode,
	input  logic                         cfg_transparency,

	// Fetch bus
	output logic                         bus_vld,
	output logic [W_ADDR-1:0]            bus_addr,
	output ppu_bus_pkg::bus_size_e       bus_size,
	input  logic                         bus_rdy,
	input  ppu_bus_pkg::bus_word_u       bus_data,

	// Pixel output
	output logic                         out_vld,
	input  logic                         out_rdy,
	output logic                         out_alpha,
	output logic [ppu_cfg_pkg::W_PIX-1:0] out_pix
);

	import ppu_bus_pkg::*;

	logic accept;
	logic tile_load;
	logic pix_load;
	logic streaming;
	logic sel_tile;
	logic tile_end;
	logic word_empty;

	logic [W_COORD-1:0]      u;
	logic [W_COORD-1:0]      v;
	logic [W_PAL_BANK-1:0]   pal_bank;
	logic [$clog2(W_DATA)-1:0] start_bit;

	// Coordinates of a flush that landed on a held transfer load only
	// when that transfer completes, keeping its address stable
	logic bus_held;
	logic flush_wait;
	logic coord_flush;

	assign accept   = out_vld && out_rdy;
	assign bus_held = bus_vld && !bus_rdy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flush_wait <= 1'b0;
		end else if (bus_rdy) begin
			flush_wait <= 1'b0;
		end else if (flush && bus_vld) begin
			flush_wait <= 1'b1;
		end
	end

	assign coord_flush = (flush && !bus_held) || (flush_wait && bus_rdy);

	// --------------------------------------------------------------------------
	// Blocks

	ppu_bg_fetch_fsm u_fsm (
		.clk        (clk),
		.rst_n      (rst_n),
		.en         (en),
		.flush      (flush),
		.bus_rdy    (bus_rdy),
		.tile_end   (tile_end),
		.word_empty (word_empty),
		.accept     (accept),
		.bus_vld    (bus_vld),
		.sel_tile   (sel_tile),
		.tile_load  (tile_load),
		.pix_load   (pix_load),
		.streaming  (streaming)
	);

	ppu_tile_pixel_counter #(
		.W_COORD (W_COORD)
	) u_counter (
		.clk           (clk),
		.rst_n         (rst_n),
		.flush         (coord_flush),
		.accept        (accept),
		.beam_x        (beam_x),
		.beam_y        (beam_y),
		.cfg_scroll_x  (cfg_scroll_x),
		.cfg_scroll_y  (cfg_scroll_y),
		.cfg_log_w     (cfg_log_w),
		.cfg_log_h     (cfg_log_h),
		.cfg_tile_size (cfg_tile_size),
		.u             (u),
		.v             (v),
		.tile_end      (tile_end)
	);

	ppu_bg_addr_gen #(
		.W_COORD (W_COORD),
		.W_ADDR  (W_ADDR)
	) u_addr_gen (
		.clk              (clk),
		.rst_n            (rst_n),
		.u                (u),
		.v                (v),
		.tile_load        (tile_load),
		.bus_data         (bus_data),
		.sel_tile         (sel_tile),
		.cfg_log_w        (cfg_log_w),
		.cfg_tile_size    (cfg_tile_size),
		.cfg_pixel_mode   (cfg_pixel_mode),
		.cfg_tilemap_base (cfg_tilemap_base),
		.cfg_tileset_base (cfg_tileset_base),
		.bus_addr         (bus_addr),
		.bus_size         (bus_size),
		.pal_bank         (pal_bank),
		.start_bit        (start_bit)
	);

	ppu_pixel_gearbox #(
		.W_DATA (W_DATA)
	) u_gearbox (
		.clk              (clk),
		.rst_n            (rst_n),
		.flush            (flush),
		.pix_load         (pix_load),
		.bus_data         (bus_data),
		.start_bit        (start_bit),
		.accept           (accept),
		.cfg_pixel_mode   (cfg_pixel_mode),
		.pal_bank         (pal_bank),
		.cfg_transparency (cfg_transparency),
		.en               (en),
		.streaming        (streaming),
		.out_vld          (out_vld),
		.out_alpha        (out_alpha),
		.out_pix          (out_pix),
		.word_empty       (word_empty)
	);

endmodule

/* rtl/ppu_bg_addr_gen.sv */
//--------------------------------------------------------------------------
// Tilemap and tileset address generation with the current tile register
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module ppu_bg_addr_gen #(
	parameter int W_COORD = 9,
	parameter int W_ADDR  = 16
) (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  logic [W_COORD-1:0]                         u,
	input  logic [W_COORD-1:0]                         v,
	input  logic                                       tile_load,
	input  ppu_bus_pkg::bus_word_u                     bus_data,
	input  logic                                       sel_tile,
	input  logic [$clog2(W_COORD)-1:0]                 cfg_log_w,
	input  logic                                       cfg_tile_size,
	input  ppu_cfg_pkg::pixel_mode_e                   cfg_pixel_mode,
	input  logic [W_ADDR-1:0]                          cfg_tilemap_base,
	input  logic [W_ADDR-1:0]                          cfg_tileset_base,
	output logic [W_ADDR-1:0]                          bus_addr,
	output ppu_bus_pkg::bus_size_e                     bus_size,
	output logic [ppu_bus_pkg::W_PAL_BANK-1:0]         pal_bank,
	output logic [$clog2(ppu_bus_pkg::W_DATA)-1:0]     start_bit
);

	import ppu_cfg_pkg::*;
	import ppu_bus_pkg::*;

	localparam int W_LOG = $clog2(W_COORD);
	localparam int W_SH  = W_LOG + 1;
	localparam int W_BIT = $clog2(W_DATA);
	// Bit index into the tileset, word address plus bit-in-word
	localparam int W_BI  = W_ADDR + W_BIT;

	logic [W_TILENUM-1:0]    tile_num;
	logic [W_SH-1:0]         tile_log;
	logic [W_SH-1:0]         row_log;
	logic [LOG_TILE_MAX-1:0] tile_mask;
	logic [LOG_TILE_MAX-1:0] u_in_tile;
	logic [LOG_TILE_MAX-1:0] v_in_tile;
	logic [W_ADDR-1:0]       tile_idx;
	logic [W_ADDR-1:0]       tilemap_addr;
	logic [W_ADDR-1:0]       pixel_addr;
	logic [W_BI-1:0]         pix_idx;
	logic [W_BI-1:0]         bit_idx;

	// --------------------------------------------------------------------------
	// Tile register, loaded from the tilemap entry view

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tile_num <= '0;
			pal_bank <= '0;
		end else if (tile_load) begin
			tile_num <= bus_data.tile_entry.tile_num;
			pal_bank <= bus_data.tile_entry.pal_bank;
		end
	end

	// --------------------------------------------------------------------------
	// Tilemap address

	assign tile_log = cfg_tile_size ? W_SH'(LOG_TILE_MAX) : W_SH'(LOG_TILE_MAX - 1);

	// Playfield width in tiles is 2^row_log
	assign row_log = {1'b0, cfg_log_w} + W_SH'(1) - tile_log;

	assign tile_idx = (W_ADDR'(v >> tile_log) << row_log) | W_ADDR'(u >> tile_log);
	assign tilemap_addr = cfg_tilemap_base + tile_idx;

	// --------------------------------------------------------------------------
	// Tileset address

	assign tile_mask = {cfg_tile_size, {(LOG_TILE_MAX-1){1'b1}}};
	assign u_in_tile = u[LOG_TILE_MAX-1:0] & tile_mask;
	assign v_in_tile = v[LOG_TILE_MAX-1:0] & tile_mask;

	// Tiles stored row by row, each tile 2^(2*tile_log) pixels
	assign pix_idx = (W_BI'(tile_num) << {tile_log, 1'b0})
		+ (W_BI'(v_in_tile) << tile_log)
		+ W_BI'(u_in_tile);
	assign bit_idx = pix_idx << mode_log_bpp(cfg_pixel_mode);

	assign pixel_addr = cfg_tileset_base + bit_idx[W_BI-1:W_BIT];
	assign start_bit  = bit_idx[W_BIT-1:0];

	// Tilemap source only during the tile fetch
	assign bus_addr = sel_tile ? tilemap_addr : pixel_addr;
	assign bus_size = sel_tile ? SIZE_BYTE : SIZE_WORD;

endmodule

/* rtl/ppu_bg_fetch_fsm.sv */
//--------------------------------------------------------------------------
// Background fetch sequencer: tile fetch, pixel fetch and streaming states
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module ppu_bg_fetch_fsm (
	input  logic clk,
	input  logic rst_n,
	input  logic en,
	input  logic flush,
	input  logic bus_rdy,
	input  logic tile_end,
	input  logic word_empty,
	input  logic accept,
	output logic bus_vld,
	output logic sel_tile,
	output logic tile_load,
	output logic pix_load,
	output logic streaming
);

	typedef enum logic [1:0] {
		IDLE       = 2'd0,
		FETCH_TILE = 2'd1,
		FETCH_PIX  = 2'd2,
		STREAM     = 2'd3
	} state_e;

	state_e state;

	// Set when a flush lands on a transfer that has not completed yet
	logic pending;

	// Transfer is on the bus and will not complete this cycle
	logic held;

	assign bus_vld   = (state == FETCH_TILE) || (state == FETCH_PIX);
	assign sel_tile  = (state == FETCH_TILE);
	assign streaming = (state == STREAM);
	assign held      = bus_vld && !bus_rdy;

	// Completions of a transfer made stale by a flush load nothing
	assign tile_load = (state == FETCH_TILE) && bus_rdy && !pending && !flush;
	assign pix_load  = (state == FETCH_PIX) && bus_rdy && !pending && !flush;

	// --------------------------------------------------------------------------
	// State register

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= IDLE;
			pending <= 1'b0;
		end else if (pending) begin
			// Stale transfer still held, restart once it completes
			if (bus_rdy) begin
				pending <= 1'b0;
				state   <= en ? FETCH_TILE : IDLE;
			end
		end else if (flush) begin
			if (held) begin
				pending <= 1'b1;
			end else begin
				state <= en ? FETCH_TILE : IDLE;
			end
		end else if (!en) begin
			// Layer off, park once the bus is quiet
			if (!held) begin
				state <= IDLE;
			end
		end else begin
			case (state)
				IDLE: begin
					// Nothing to do until the next flush
					state <= IDLE;
				end
				FETCH_TILE: begin
					if (bus_rdy) begin
						state <= FETCH_PIX;
					end
				end
				FETCH_PIX: begin
					if (bus_rdy) begin
						state <= STREAM;
					end
				end
				STREAM: begin
					// Tile runout wins, a fresh tile always needs fresh pixels
					if (accept && tile_end) begin
						state <= FETCH_TILE;
					end else if (accept && word_empty) begin
						state <= FETCH_PIX;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

/* rtl/ppu_bus_pkg.sv */
//--------------------------------------------------------------------------
// Fetch bus definitions: data word views and transfer size codes
//--------------------------------------------------------------------------

package ppu_bus_pkg;

	// Bus data width
	localparam int W_DATA = 32;

	// Tilemap entry fields
	localparam int W_TILENUM  = 8;
	localparam int W_PAL_BANK = 4;

	// Transfer size, byte for tilemap entries and full word for pixels
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_WORD = 2'd2
	} bus_size_e;

	// Tilemap entry as it sits in the low bits of a fetched word
	typedef struct packed {
		logic [W_DATA-W_PAL_BANK-W_TILENUM-1:0] reserved;
		logic [W_PAL_BANK-1:0]                  pal_bank;
		logic [W_TILENUM-1:0]                   tile_num;
	} tile_entry_t;

	// One fetched word, read as a tilemap entry after a tile fetch
	// or as packed pixel bits after a tileset fetch
	typedef union packed {
		tile_entry_t       tile_entry;
		logic [W_DATA-1:0] pixels;
	} bus_word_u;

endpackage

/* rtl/ppu_cfg_pkg.sv */
//--------------------------------------------------------------------------
// Background layer configuration: pixel modes, coordinate limits and the
// pixel mode decode function
//--------------------------------------------------------------------------

package ppu_cfg_pkg;

	// Width of the palette index presented on the output
	localparam int W_PIX = 8;

	// Pixel-in-tile position bits, enough for the largest (16 pixel) tile
	localparam int LOG_TILE_MAX = 4;

	// Pixel depth, encoded so the code itself is log2 of the bit width
	typedef enum logic [1:0] {
		MODE_1BPP = 2'd0,
		MODE_2BPP = 2'd1,
		MODE_4BPP = 2'd2,
		MODE_8BPP = 2'd3
	} pixel_mode_e;

	// --------------------------------------------------------------------------
	// Mode decode

	// log2 of the pixel width in bits
	function automatic logic [2:0] mode_log_bpp(input pixel_mode_e mode);
		logic [2:0] log_bpp;
		case (mode)
			MODE_1BPP: log_bpp = 3'd0;
			MODE_2BPP: log_bpp = 3'd1;
			MODE_4BPP: log_bpp = 3'd2;
			MODE_8BPP: log_bpp = 3'd3;
			default:   log_bpp = 3'd0;
		endcase
		return log_bpp;
	endfunction

endpackage

/* rtl/ppu_pixel_gearbox.sv */
//--------------------------------------------------------------------------
// Pixel shifter: one palette index per accepted output, alpha and valid
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module ppu_pixel_gearbox #(
	parameter int W_DATA = 32
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              flush,
	input  logic                              pix_load,
	input  ppu_bus_pkg::bus_word_u            bus_data,
	input  logic [$clog2(W_DATA)-1:0]         start_bit,
	input  logic                              accept,
	input  ppu_cfg_pkg::pixel_mode_e          cfg_pixel_mode,
	input  logic [ppu_bus_pkg::W_PAL_BANK-1:0] pal_bank,
	input  logic                              cfg_transparency,
	input  logic                              en,
	input  logic                              streaming,
	output logic                              out_vld,
	output logic                              out_alpha,
	output logic [ppu_cfg_pkg::W_PIX-1:0]     out_pix,
	output logic                              word_empty
);

	import ppu_cfg_pkg::*;
	import ppu_bus_pkg::*;

	localparam int W_BIT = $clog2(W_DATA);

	// Unconsumed pixel bits, current pixel at the bottom
	logic [W_DATA-1:0] shift_q;

	// Bits of the word consumed so far, including the start offset
	logic [W_BIT:0]   bit_ctr;
	logic [W_BIT+1:0] bit_sum;
	logic [W_BIT:0]   bpp;

	logic [W_PIX-1:0] pix_mask;
	logic [W_PIX-1:0] index;

	assign bpp = {{W_BIT{1'b0}}, 1'b1} << mode_log_bpp(cfg_pixel_mode);

	// --------------------------------------------------------------------------
	// Word shifter

	always_ff @(posedge clk) begin
		if (pix_load) begin
			shift_q <= bus_data.pixels >> start_bit;
		end else if (accept) begin
			shift_q <= shift_q >> bpp;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_ctr <= '0;
		end else if (pix_load) begin
			bit_ctr <= {1'b0, start_bit};
		end else if (accept) begin
			bit_ctr <= bit_sum[W_BIT:0];
		end
	end

	// Word runs dry once the current pixel is taken
	assign bit_sum    = {1'b0, bit_ctr} + {1'b0, bpp};
	assign word_empty = (bit_sum >= (W_BIT+2)'(W_DATA));

	// --------------------------------------------------------------------------
	// Output formation

	// Low bpp bits, all 8 in 8 bpp mode
	assign pix_mask = ~({W_PIX{1'b1}} << bpp);
	assign index    = shift_q[W_PIX-1:0] & pix_mask;

	// Narrow modes pick their palette row from the tile's bank
	assign out_pix = (cfg_pixel_mode == MODE_8BPP) ? index :
		({pal_bank, {(W_PIX-W_PAL_BANK){1'b0}}} | index);

	assign out_alpha = en && !(cfg_transparency && (index == '0));

	// Disabled layer streams transparent pixels so the blender never stalls
	assign out_vld = !en || (streaming && !flush);

endmodule

/* rtl/ppu_tile_pixel_counter.sv */
//--------------------------------------------------------------------------
// Playfield coordinate counters and pixel-in-tile column counter
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module ppu_tile_pixel_counter #(
	parameter int W_COORD = 9
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       flush,
	input  logic                       accept,
	input  logic [W_COORD-1:0]         beam_x,
	input  logic [W_COORD-1:0]         beam_y,
	input  logic [W_COORD-1:0]         cfg_scroll_x,
	input  logic [W_COORD-1:0]         cfg_scroll_y,
	input  logic [$clog2(W_COORD)-1:0] cfg_log_w,
	input  logic [$clog2(W_COORD)-1:0] cfg_log_h,
	input  logic                       cfg_tile_size,
	output logic [W_COORD-1:0]         u,
	output logic [W_COORD-1:0]         v,
	output logic                       tile_end
);

	import ppu_cfg_pkg::*;

	// Playfield dimension masks, size is 2^(log+1)
	logic [W_COORD:0]   w_span;
	logic [W_COORD:0]   h_span;
	logic [W_COORD-1:0] w_mask;
	logic [W_COORD-1:0] h_mask;

	// Wrapped coordinates of the flush position
	logic [W_COORD-1:0] u_flush;
	logic [W_COORD-1:0] v_flush;

	// Column within the current tile and its last value
	logic [LOG_TILE_MAX-1:0] tile_col;
	logic [LOG_TILE_MAX-1:0] tile_last;

	assign w_span = {{W_COORD{1'b1}}, 1'b0} << cfg_log_w;
	assign h_span = {{W_COORD{1'b1}}, 1'b0} << cfg_log_h;
	assign w_mask = ~w_span[W_COORD-1:0];
	assign h_mask = ~h_span[W_COORD-1:0];

	assign u_flush = (beam_x + cfg_scroll_x) & w_mask;
	assign v_flush = (beam_y + cfg_scroll_y) & h_mask;

	// 7 for 8-pixel tiles, 15 for 16-pixel tiles
	assign tile_last = {cfg_tile_size, {(LOG_TILE_MAX-1){1'b1}}};
	assign tile_end  = (tile_col == tile_last);

	// --------------------------------------------------------------------------
	// Counters

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			u        <= '0;
			v        <= '0;
			tile_col <= '0;
		end else if (flush) begin
			u        <= u_flush;
			v        <= v_flush;
			tile_col <= u_flush[LOG_TILE_MAX-1:0] & tile_last;
		end else if (accept) begin
			// Playfield width is a whole number of tiles so both wrap together
			u <= (u + 1'b1) & w_mask;
			if (tile_end) begin
				tile_col <= '0;
			end else begin
				tile_col <= tile_col + 1'b1;
			end
		end
	end

endmodule

/* testbench/ppu_background_props.sv */
//--------------------------------------------------------------------------
// Bus handshake, reset and disabled-layer assertions for the background layer
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module ppu_background_props #(
	parameter int W_ADDR = 16
) (
	input logic              clk,
	input logic              rst_n,
	input logic              en,
	input logic              bus_vld,
	input logic              bus_rdy,
	input logic [W_ADDR-1:0] bus_addr,
	input logic [1:0]        bus_size,
	input logic              out_vld,
	input logic              out_alpha
);

	// Failed assertion count, read by the testbench at the end of the run
	int prop_fails = 0;

	// No transfer during reset or on the first cycle out of it
	reset_quiet: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> !bus_vld)
		else begin
			$error("bus_vld high during or right after reset");
			prop_fails++;
		end

	// A stalled request keeps its address and size until bus_rdy
	bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(bus_vld && !bus_rdy) |=> (bus_vld && $stable(bus_addr) && $stable(bus_size)))
		else begin
			$error("bus request changed or dropped while stalled");
			prop_fails++;
		end

	// Disabled layer streams transparent pixels
	off_transparent: assert property (@(posedge clk) disable iff (!rst_n)
		!en |-> (out_vld && !out_alpha))
		else begin
			$error("layer disabled but output not valid and transparent");
			prop_fails++;
		end

endmodule

bind ppu_background ppu_background_props #(.W_ADDR(W_ADDR)) u_props (
	.clk       (clk),
	.rst_n     (rst_n),
	.en        (en),
	.bus_vld   (bus_vld),
	.bus_rdy   (bus_rdy),
	.bus_addr  (bus_addr),
	.bus_size  (bus_size),
	.out_vld   (out_vld),
	.out_alpha (out_alpha)
);

/* testbench/tb_ppu_background.sv */
//--------------------------------------------------------------------------
// Background layer testbench: clock, reset, hashed memory, stimulus, checks
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_ppu_background;

	import ppu_cfg_pkg::*;

	localparam int W_COORD = 9;
	localparam int W_ADDR  = 16;

	// Run length limit: lines times pixels times worst cycles per pixel
	localparam int N_LINES     = 9;
	localparam int LINE_PIX    = 64;
	localparam int CYC_PER_PIX = 32;
	localparam int MAX_CYCLES  = N_LINES * LINE_PIX * CYC_PER_PIX + 1000;

	logic clk;
	logic rst_n;
	logic [W_COORD-1:0] beam_x;
	logic [W_COORD-1:0] beam_y;
	logic en;
	logic flush;
	logic [W_COORD-1:0] cfg_scroll_x;
	logic [W_COORD-1:0] cfg_scroll_y;
	logic [3:0] cfg_log_w;
	logic [3:0] cfg_log_h;
	logic [W_ADDR-1:0] cfg_tilemap_base;
	logic [W_ADDR-1:0] cfg_tileset_base;
	logic cfg_tile_size;
	pixel_mode_e cfg_pixel_mode;
	logic cfg_transparency;
	logic bus_vld;
	logic [W_ADDR-1:0] bus_addr;
	ppu_bus_pkg::bus_size_e bus_size;
	logic bus_rdy;
	logic [31:0] bus_data;
	logic out_vld;
	logic out_rdy;
	logic out_alpha;
	logic [W_PIX-1:0] out_pix;

	integer seed;
	int cycles;
	int errors;
	int checks;
	int tests_run;
	int tests_failed;
	int err_mark;
	// Model position in the playfield
	int exp_u;
	int exp_v;

	// --------------------------------------------------------------------------
	// Memory model, every word a hash of its full address

	function automatic logic [31:0] mem_word(input logic [W_ADDR-1:0] addr);
		logic [31:0] x;
		x = {addr, ~addr} ^ 32'h5bd1e995;
		x = x * 32'h9e3779b1;
		x = x ^ (x >> 15);
		return x;
	endfunction

	// Data follows the address at all times, only bus_rdy marks completion
	assign bus_data = mem_word(bus_addr);

	ppu_background #(
		.W_COORD (W_COORD),
		.W_ADDR  (W_ADDR)
	) DUT (
		.clk (clk), .rst_n (rst_n), .beam_x (beam_x), .beam_y (beam_y),
		.en (en), .flush (flush),
		.cfg_scroll_x (cfg_scroll_x), .cfg_scroll_y (cfg_scroll_y),
		.cfg_log_w (cfg_log_w), .cfg_log_h (cfg_log_h),
		.cfg_tilemap_base (cfg_tilemap_base), .cfg_tileset_base (cfg_tileset_base),
		.cfg_tile_size (cfg_tile_size), .cfg_pixel_mode (cfg_pixel_mode),
		.cfg_transparency (cfg_transparency),
		.bus_vld (bus_vld), .bus_addr (bus_addr), .bus_size (bus_size),
		.bus_rdy (bus_rdy), .bus_data (bus_data),
		.out_vld (out_vld), .out_rdy (out_rdy), .out_alpha (out_alpha), .out_pix (out_pix)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run exceeded %0d cycles without finishing", MAX_CYCLES);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// --------------------------------------------------------------------------
	// Reference pixel from the playfield coordinate

	task automatic predict(input int u, input int v, output logic [7:0] pix,
		output logic alpha);
		int tl;
		int lbpp;
		int tidx;
		logic [31:0] entry;
		logic [31:0] pidx;
		logic [31:0] bi;
		logic [31:0] word;
		logic [7:0] idx;
		tl = cfg_tile_size ? 4 : 3;
		case (cfg_pixel_mode)
			MODE_1BPP: lbpp = 0;
			MODE_2BPP: lbpp = 1;
			MODE_4BPP: lbpp = 2;
			default:   lbpp = 3;
		endcase
		// Tilemap row holds 2^(log_w+1-tl) entries
		tidx = ((v >> tl) << (cfg_log_w + 1 - tl)) | (u >> tl);
		entry = mem_word(W_ADDR'(cfg_tilemap_base + tidx));
		pidx = (32'(entry[7:0]) << (2 * tl)) + ((v & ((1 << tl) - 1)) << tl)
			+ (u & ((1 << tl) - 1));
		bi = pidx << lbpp;
		word = mem_word(W_ADDR'(cfg_tileset_base + bi[31:5]));
		idx = 8'((word >> bi[4:0]) & ((32'd1 << (1 << lbpp)) - 1));
		pix = (lbpp == 3) ? idx : ({entry[11:8], 4'h0} | idx);
		alpha = !(cfg_transparency && (idx == 8'd0));
	endtask

	task automatic check_pixel();
		logic [7:0] exp_pix;
		logic exp_alpha;
		predict(exp_u, exp_v, exp_pix, exp_alpha);
		checks++;
		assert (out_pix == exp_pix) else begin
			$display("[ERROR] %0t: pixel at u=%0d v=%0d is %h, expected %h",
				$time, exp_u, exp_v, out_pix, exp_pix);
			errors++;
		end
		assert (out_alpha == exp_alpha) else begin
			$display("[ERROR] %0t: alpha at u=%0d v=%0d is %b, expected %b",
				$time, exp_u, exp_v, out_alpha, exp_alpha);
			errors++;
		end
		exp_u = (exp_u + 1) & ((1 << (cfg_log_w + 1)) - 1);
	endtask

	// Tileset sits above the tilemap, so the address tells the fetch kind
	task automatic check_fetch_size();
		ppu_bus_pkg::bus_size_e exp_size;
		if (bus_addr >= cfg_tileset_base) begin
			exp_size = ppu_bus_pkg::SIZE_WORD;
		end else begin
			exp_size = ppu_bus_pkg::SIZE_BYTE;
		end
		assert (bus_size == exp_size) else begin
			$display("[ERROR] %0t: fetch at %h has size %0d, expected %0d",
				$time, bus_addr, bus_size, exp_size);
			errors++;
		end
	endtask

	// --------------------------------------------------------------------------
	// Stimulus

	// Config only changes with the bus idle and the output stalled
	task automatic configure(input logic tile16, input pixel_mode_e mode,
		input int sx, input int lw, input logic transp);
		@(posedge clk);
		#1;
		out_rdy = 1'b0;
		bus_rdy = 1'b1;
		while (bus_vld) begin
			@(posedge clk);
			#1;
		end
		cfg_tile_size = tile16;
		cfg_pixel_mode = mode;
		cfg_scroll_x = W_COORD'(sx);
		cfg_log_w = 4'(lw);
		cfg_transparency = transp;
	endtask

	task automatic start_line(input int bx, input int by);
		@(posedge clk);
		#1;
		beam_x = W_COORD'(bx);
		beam_y = W_COORD'(by);
		flush = 1'b1;
		exp_u = (bx + cfg_scroll_x) & ((1 << (cfg_log_w + 1)) - 1);
		exp_v = (by + cfg_scroll_y) & ((1 << (cfg_log_h + 1)) - 1);
		@(posedge clk);
		#1;
		flush = 1'b0;
	endtask

	// Accept n pixels, with random bus stalls and output gaps if asked
	task automatic stream(input int n, input logic rnd);
		int got;
		logic [31:0] r;
		got = 0;
		while (got < n) begin
			@(posedge clk);
			#1;
			r = $random(seed);
			out_rdy = rnd ? (r[0] | r[1]) : 1'b1;
			bus_rdy = rnd ? r[4] : 1'b1;
			@(negedge clk);
			if (bus_vld && bus_rdy) begin
				check_fetch_size();
			end
			if (out_vld && out_rdy) begin
				check_pixel();
				got++;
			end
		end
	endtask

	function automatic int total_errors();
		return errors + DUT.u_props.prop_fails;
	endfunction

	task automatic end_test(input int num, input string name);
		int n;
		n = total_errors() - err_mark;
		tests_run++;
		if (n != 0) begin
			tests_failed++;
		end
		$display("test %0d %s: %s (%0d errors)", num, name, (n == 0) ? "ok" : "failed", n);
		err_mark = total_errors();
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		beam_x = '0;
		beam_y = '0;
		en = 1'b1;
		flush = 1'b0;
		cfg_scroll_x = '0;
		cfg_scroll_y = W_COORD'(3);
		cfg_log_w = 4'd5;
		cfg_log_h = 4'd4;
		cfg_tilemap_base = 16'h1000;
		cfg_tileset_base = 16'h4000;
		cfg_tile_size = 1'b0;
		cfg_pixel_mode = MODE_4BPP;
		cfg_transparency = 1'b0;
		bus_rdy = 1'b0;
		out_rdy = 1'b0;
		seed = 32'h69542cde;
		cycles = 0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		err_mark = 0;
		exp_u = 0;
		exp_v = 0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Full 64 pixel line over 8 tiles and 8 words
		configure(1'b0, MODE_4BPP, 0, 5, 1'b0);
		start_line(0, 5);
		stream(LINE_PIX, 1'b0);
		end_test(1, "8px tiles 4bpp line");

		// Playfield of 32 pixels, so the line wraps twice
		configure(1'b1, MODE_1BPP, 37, 4, 1'b0);
		start_line(0, 10);
		stream(LINE_PIX, 1'b0);
		configure(1'b1, MODE_2BPP, 37, 4, 1'b0);
		start_line(0, 11);
		stream(LINE_PIX, 1'b0);
		configure(1'b1, MODE_8BPP, 37, 4, 1'b0);
		start_line(0, 12);
		stream(LINE_PIX, 1'b0);
		end_test(2, "16px tiles with scroll wrap");

		configure(1'b0, MODE_4BPP, 13, 6, 1'b0);
		start_line(3, 20);
		stream(LINE_PIX, 1'b1);
		end_test(3, "bus stalls and output gaps");

		// 1bpp and 2bpp give plenty of zero indices
		configure(1'b0, MODE_2BPP, 5, 5, 1'b1);
		start_line(0, 7);
		stream(LINE_PIX, 1'b1);
		configure(1'b1, MODE_1BPP, 9, 5, 1'b1);
		start_line(0, 8);
		stream(LINE_PIX, 1'b1);
		end_test(4, "transparency");

		// Disabled layer, then enable and flush twice mid-line
		configure(1'b0, MODE_4BPP, 0, 6, 1'b0);
		@(posedge clk);
		#1;
		en = 1'b0;
		repeat (16) begin
			@(posedge clk);
			#1;
			out_rdy = 1'($random(seed));
			@(negedge clk);
			assert (out_vld && !out_alpha) else begin
				$display("[ERROR] %0t: disabled layer gave vld=%b alpha=%b",
					$time, out_vld, out_alpha);
				errors++;
			end
		end
		@(posedge clk);
		#1;
		en = 1'b1;
		start_line(40, 2);
		stream(20, 1'b1);
		start_line(101, 2);
		stream(24, 1'b1);
		end_test(5, "enable and mid-line flush");

		$display("tests run %0d, failed %0d, pixel checks %0d, errors %0d",
			tests_run, tests_failed, checks, total_errors());
		if (total_errors() == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* verilog.f */
rtl/ppu_cfg_pkg.sv
rtl/ppu_bus_pkg.sv
rtl/ppu_bg_fetch_fsm.sv
rtl/ppu_tile_pixel_counter.sv
rtl/ppu_bg_addr_gen.sv
rtl/ppu_pixel_gearbox.sv
rtl/ppu_background.sv
testbench/ppu_background_props.sv
testbench/tb_ppu_background.sv
